// ==== Bender.yml ====
package:
  name: ysyx_ifu

sources:
  - rtl/ysyx_core_pkg.sv
  - rtl/ysyx_bus_pkg.sv
  - rtl/ifu_l1i.sv
  - rtl/ifu_redirect.sv
  - rtl/ifu_fetch.sv
  - rtl/ysyx_ifu.sv
  - target: test
    files:
      - verification/tb_ysyx_ifu.sv

// ==== rtl/ifu_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifu_fetch (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         hit,
  input  ysyx_core_pkg::inst_t         inst,
  input  ysyx_core_pkg::redirect_t     redirect,
  output logic [31:0]                  pc,
  output logic                         fetch_valid,
  output ysyx_core_pkg::fetch_packet_t packet,
  input  logic                         credit_return
);

  logic [ysyx_core_pkg::credit_len-1:0] credits;
  logic [ysyx_core_pkg::credit_len-1:0] credit_inc;
  logic [ysyx_core_pkg::credit_len-1:0] credit_dec;

  logic        is_jal;
  logic        is_branch;
  logic        branch_taken;
  logic        taken;
  logic [31:0] j_imm;
  logic [31:0] b_imm;
  logic [31:0] next_pc;

  // static predecode.
  assign is_jal = (inst.j.opcode == ysyx_core_pkg::op_jal);
  assign is_branch = (inst.b.opcode == ysyx_core_pkg::op_branch);

  assign j_imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                  inst.j.imm10_1, 1'b0};
  assign b_imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                  inst.b.imm4_1, 1'b0};

  // backward branches are taken.
  assign branch_taken = is_branch && inst.b.imm12;
  assign taken = is_jal || branch_taken;

  always_comb begin
    if (is_jal) begin
      next_pc = pc + j_imm;
    end else if (branch_taken) begin
      next_pc = pc + b_imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  assign fetch_valid = hit && (credits != '0) && !redirect.valid;

  assign packet.pc = pc;
  assign packet.inst = inst;
  assign packet.predicted_taken = taken;

  assign credit_inc = {{(ysyx_core_pkg::credit_len - 1){1'b0}}, credit_return};
  assign credit_dec = {{(ysyx_core_pkg::credit_len - 1){1'b0}}, fetch_valid};

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= ysyx_bus_pkg::reset_pc;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else if (fetch_valid) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= ysyx_core_pkg::fetch_credits[ysyx_core_pkg::credit_len-1:0];
    end else begin
      credits <= credits + credit_inc - credit_dec; // both may happen together.
    end
  end

  // decode must never return more than it was given.
  a_credit_bound: assert property (
    @(posedge clock) disable iff (reset)
    credits <= ysyx_core_pkg::fetch_credits
  );

endmodule

`default_nettype wire

// ==== rtl/ifu_l1i.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifu_l1i (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [31:0]              pc,
  input  logic                     invalidate,
  output ysyx_bus_pkg::bus_req_t   bus_req,
  input  logic                     bus_ready,
  input  ysyx_bus_pkg::bus_resp_t  bus_resp,
  output logic                     hit,
  output ysyx_core_pkg::inst_t     inst,
  output logic                     idle
);

  typedef enum logic [1:0] {
    s_idle,
    s_rd_even,
    s_rd_odd,
    s_wb
  } state_t;

  state_t state;

  logic [31:0] data_mem [ysyx_core_pkg::l1i_lines][ysyx_core_pkg::l1i_words];
  logic [ysyx_core_pkg::l1i_tag_len-1:0] tag_mem [ysyx_core_pkg::l1i_lines];
  logic [ysyx_core_pkg::l1i_lines-1:0] line_valid;

  logic [ysyx_core_pkg::l1i_tag_len-1:0] addr_tag;
  logic [ysyx_core_pkg::l1i_idx_len-1:0] addr_idx;
  logic [ysyx_core_pkg::l1i_line_len-1:0] addr_off;

  logic [ysyx_core_pkg::l1i_tag_len-1:0] miss_tag;
  logic [ysyx_core_pkg::l1i_idx_len-1:0] miss_idx;

  logic reading;
  logic word_sel;
  logic req_sent;
  logic fill_en;
  logic inval_pending;
  logic clear_now;

  assign addr_tag = pc[31 -: ysyx_core_pkg::l1i_tag_len];
  assign addr_idx = pc[ysyx_core_pkg::l1i_line_len + 2 +: ysyx_core_pkg::l1i_idx_len];
  assign addr_off = pc[2 +: ysyx_core_pkg::l1i_line_len];

  assign idle = (state == s_idle);
  assign reading = (state == s_rd_even) || (state == s_rd_odd);
  assign word_sel = (state == s_rd_odd); // offset is a single bit.

  // no hits while a fence.i is waiting to clear.
  assign hit = idle && !invalidate && !inval_pending && line_valid[addr_idx] &&
               (tag_mem[addr_idx] == addr_tag);
  assign inst = data_mem[addr_idx][addr_off];

  assign bus_req.arvalid = reading && !req_sent;
  assign bus_req.araddr = {miss_tag, miss_idx, word_sel, 2'b00};

  assign fill_en = reading && bus_resp.rvalid;
  assign clear_now = (invalidate || inval_pending) && (idle || state == s_wb);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
      req_sent <= 1'b0;
      line_valid <= '0;
      inval_pending <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (!hit) begin
            state <= s_rd_even;
          end
        end
        s_rd_even: begin
          if (bus_resp.rvalid) begin
            state <= s_rd_odd;
          end
        end
        s_rd_odd: begin
          if (bus_resp.rvalid) begin
            state <= s_wb;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase

      if (bus_resp.rvalid) begin
        req_sent <= 1'b0;
      end else if (bus_req.arvalid && bus_ready) begin
        req_sent <= 1'b1; // wait for the answer.
      end

      if (state == s_rd_odd && bus_resp.rvalid) begin
        line_valid[miss_idx] <= 1'b1;
      end

      if (clear_now) begin
        line_valid <= '0;
        inval_pending <= 1'b0;
      end else if (invalidate) begin
        inval_pending <= 1'b1;
      end
    end
  end

  // line storage and miss address.
  always_ff @(posedge clock) begin
    if (idle) begin
      miss_tag <= addr_tag;
      miss_idx <= addr_idx;
    end
    if (fill_en) begin
      data_mem[miss_idx][word_sel] <= bus_resp.rdata;
    end
    if (fill_en && word_sel) begin
      tag_mem[miss_idx] <= miss_tag;
    end
  end

  // one read in flight at a time.
  a_one_outstanding: assert property (
    @(posedge clock) disable iff (reset)
    bus_req.arvalid && bus_ready |=> !bus_req.arvalid
  );

  // bus must not answer without an outstanding request.
  a_no_rvalid_idle: assert property (
    @(posedge clock) disable iff (reset)
    bus_resp.rvalid |-> !idle
  );

endmodule

`default_nettype wire

// ==== rtl/ifu_redirect.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifu_redirect (
  input  logic                     clock,
  input  logic                     reset,
  input  ysyx_core_pkg::redirect_t flush,
  input  logic                     fence_i,
  input  logic                     idle,
  output ysyx_core_pkg::redirect_t redirect,
  output logic                     invalidate
);

  logic        flush_pending;
  logic [31:0] flush_target;
  logic        fence_pending;

  // a new flush wins over the held one.
  assign redirect.valid = idle && (flush.valid || flush_pending);
  assign redirect.target = flush.valid ? flush.target : flush_target;

  assign invalidate = idle && (fence_i || fence_pending);

  always_ff @(posedge clock) begin
    if (reset) begin
      flush_pending <= 1'b0;
      fence_pending <= 1'b0;
    end else begin
      if (idle) begin
        flush_pending <= 1'b0; // released this cycle.
      end else if (flush.valid) begin
        flush_pending <= 1'b1;
      end

      if (idle) begin
        fence_pending <= 1'b0;
      end else if (fence_i) begin
        fence_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (flush.valid) begin
      flush_target <= flush.target;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ysyx_bus_pkg.sv ====
`default_nettype none

package ysyx_bus_pkg;

  // read address channel.
  typedef struct packed {
    logic                               arvalid;
    logic [ysyx_core_pkg::xlen-1:0]     araddr;
  } bus_req_t;

  // read data channel, one beat per request.
  typedef struct packed {
    logic                               rvalid;
    logic [ysyx_core_pkg::xlen-1:0]     rdata;
  } bus_resp_t;

  // first fetch address out of reset.
  localparam logic [ysyx_core_pkg::xlen-1:0] reset_pc = 32'h8000_0000;

endpackage

`default_nettype wire

// ==== rtl/ysyx_core_pkg.sv ====
`default_nettype none

package ysyx_core_pkg;

  localparam int xlen = 32;

  // cache geometry.
  localparam int l1i_idx_len = 4;
  localparam int l1i_line_len = 1;
  localparam int l1i_lines = 1 << l1i_idx_len;
  localparam int l1i_words = 1 << l1i_line_len;
  localparam int l1i_tag_len = xlen - l1i_idx_len - l1i_line_len - 2;

  // decode queue depth and credit counter width.
  localparam int fetch_credits = 4;
  localparam int credit_len = $clog2(fetch_credits + 1);

  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // same word, two immediate layouts.
  typedef union packed {
    b_type_t b;
    j_type_t j;
  } inst_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    inst_t           inst;
    logic            predicted_taken;
  } fetch_packet_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/ysyx_ifu.sv ====
`timescale 1ns/100ps
`default_nettype none

module ysyx_ifu (
  input  logic                         clock,
  input  logic                         reset,
  output ysyx_bus_pkg::bus_req_t       bus_req,
  input  logic                         bus_ready,
  input  ysyx_bus_pkg::bus_resp_t      bus_resp,
  input  ysyx_core_pkg::redirect_t     flush,
  input  logic                         fence_i,
  output logic                         fetch_valid,
  output ysyx_core_pkg::fetch_packet_t fetch_packet,
  input  logic                         credit_return
);

  logic [31:0]              pc;
  logic                     hit;
  ysyx_core_pkg::inst_t     inst;
  logic                     idle;
  ysyx_core_pkg::redirect_t redirect;
  logic                     invalidate;

  ifu_l1i u_l1i (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .invalidate (invalidate),
    .bus_req    (bus_req),
    .bus_ready  (bus_ready),
    .bus_resp   (bus_resp),
    .hit        (hit),
    .inst       (inst),
    .idle       (idle)
  );

  ifu_redirect u_redirect (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .fence_i    (fence_i),
    .idle       (idle),
    .redirect   (redirect),
    .invalidate (invalidate)
  );

  ifu_fetch u_fetch (
    .clock         (clock),
    .reset         (reset),
    .hit           (hit),
    .inst          (inst),
    .redirect      (redirect),
    .pc            (pc),
    .fetch_valid   (fetch_valid),
    .packet        (fetch_packet),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

// ==== src.f ====
rtl/ysyx_core_pkg.sv
rtl/ysyx_bus_pkg.sv
rtl/ifu_l1i.sv
rtl/ifu_redirect.sv
rtl/ifu_fetch.sv
rtl/ysyx_ifu.sv
verification/tb_ysyx_ifu.sv

// ==== verification/tb_ysyx_ifu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ysyx_ifu;

  localparam int resp_latency = 2;
  localparam int hold_cycles = 40;
  localparam int total_packets = 6 + 5 + 9 + 3 + 6 + 8;
  localparam int timeout_cycles = 40 * total_packets;

  logic                         clock;
  logic                         reset;
  ysyx_bus_pkg::bus_req_t       bus_req;
  logic                         bus_ready;
  ysyx_bus_pkg::bus_resp_t      bus_resp;
  ysyx_core_pkg::redirect_t     flush;
  logic                         fence_i;
  logic                         fetch_valid;
  ysyx_core_pkg::fetch_packet_t fetch_packet;
  logic                         credit_return;

  int          cycle;
  int          errors;
  int          errors_at_open;
  int          tests_run;
  int          tests_failed;
  int          rx_total;
  int          resp_wait;
  logic [31:0] rng;
  logic [31:0] exp_pc;
  logic [31:0] resp_addr;
  logic        accepted;
  logic        hold_credits;
  logic        hold_now;
  logic [31:0] req_log[$];
  int          credit_q[$];
  ysyx_core_pkg::fetch_packet_t rx_q[$];

  ysyx_ifu UUT (
    .clock         (clock),
    .reset         (reset),
    .bus_req       (bus_req),
    .bus_ready     (bus_ready),
    .bus_resp      (bus_resp),
    .flush         (flush),
    .fence_i       (fence_i),
    .fetch_valid   (fetch_valid),
    .fetch_packet  (fetch_packet),
    .credit_return (credit_return)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic ysyx_core_pkg::inst_t jal_word(logic [20:0] imm);
    ysyx_core_pkg::inst_t w;
    w.j.opcode = 7'b1101111;
    w.j.rd = 5'd0;
    w.j.imm20 = imm[20];
    w.j.imm19_12 = imm[19:12];
    w.j.imm11 = imm[11];
    w.j.imm10_1 = imm[10:1];
    return w;
  endfunction

  // beq x0, x0 with the given offset.
  function automatic ysyx_core_pkg::inst_t beq_word(logic [12:0] imm);
    ysyx_core_pkg::inst_t w;
    w.b.opcode = 7'b1100011;
    w.b.funct3 = 3'd0;
    w.b.rs1 = 5'd0;
    w.b.rs2 = 5'd0;
    w.b.imm12 = imm[12];
    w.b.imm11 = imm[11];
    w.b.imm10_5 = imm[10:5];
    w.b.imm4_1 = imm[4:1];
    return w;
  endfunction

  function automatic ysyx_core_pkg::inst_t word_at(logic [31:0] addr);
    if (addr == 32'h8000_0010) begin
      return jal_word(21'h00020);
    end
    if (addr == 32'h8000_0040) begin
      return beq_word(13'h1ff8); // -8.
    end
    return 32'h0000_0013; // addi x0, x0, 0.
  endfunction

  // static prediction: jal always, branches only backward.
  function automatic logic [31:0] pred_next(logic [31:0] pc);
    ysyx_core_pkg::inst_t w;
    logic signed [20:0] j_off;
    logic signed [12:0] b_off;
    w = word_at(pc);
    j_off = {w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
    b_off = {w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    if (w.j.opcode == 7'b1101111) begin
      return pc + 32'(j_off);
    end
    if (w.b.opcode == 7'b1100011 && b_off < 0) begin
      return pc + 32'(b_off);
    end
    return pc + 32'd4;
  endfunction

  function automatic ysyx_core_pkg::fetch_packet_t expect_packet(logic [31:0] pc);
    ysyx_core_pkg::fetch_packet_t p;
    p.pc = pc;
    p.inst = word_at(pc);
    p.predicted_taken = (pred_next(pc) != pc + 32'd4);
    return p;
  endfunction

  function automatic int line_requests(int from, logic [31:0] addr);
    int n;
    n = 0;
    for (int i = from; i < req_log.size(); i++) begin
      if (req_log[i][31:3] == addr[31:3]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic compare_packet(input string name, input ysyx_core_pkg::fetch_packet_t exp,
                                input ysyx_core_pkg::fetch_packet_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected pc=%h inst=%h taken=%b, actual pc=%h inst=%h taken=%b",
               name, exp.pc, exp.inst, exp.predicted_taken,
               act.pc, act.inst, act.predicted_taken);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic check_next(input string name);
    ysyx_core_pkg::fetch_packet_t act;
    while (rx_q.size() == 0) begin
      step();
    end
    act = rx_q.pop_front();
    compare_packet(name, expect_packet(exp_pc), act);
    exp_pc = pred_next(exp_pc);
  endtask

  task automatic open_test();
    errors_at_open = errors;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == errors_at_open) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - errors_at_open);
    end
  endtask

  // bus slave, one answer per accepted request.
  always @(posedge clock) begin
    accepted = !reset && bus_req.arvalid && bus_ready;
    if (accepted) begin
      resp_addr = bus_req.araddr;
      req_log.push_back(bus_req.araddr);
    end
    #1;
    bus_resp.rvalid = 1'b0;
    if (resp_wait != 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        bus_resp.rvalid = 1'b1;
        bus_resp.rdata = word_at(resp_addr);
      end
    end
    if (accepted) begin
      resp_wait = resp_latency - 1;
    end
  end

  always @(posedge clock) begin
    cycle++;
    if (!reset && fetch_valid) begin
      rx_q.push_back(fetch_packet);
      rx_total++;
      rng = xorshift(rng);
      credit_q.push_back(cycle + int'(rng[1:0])); // 0 to 3 cycles in decode.
    end
  end

  // decode sink, one credit back per cycle at most.
  always @(posedge clock) begin
    hold_now = hold_credits;
    #1;
    credit_return = 1'b0;
    if (!hold_now && credit_q.size() > 0) begin
      if (credit_q[0] <= cycle) begin
        void'(credit_q.pop_front());
        credit_return = 1'b1;
      end
    end
  end

  task automatic cold_start();
    open_test();
    repeat (6) begin
      check_next("cold start");
    end
    close_test("cold start");
  endtask

  task automatic backward_branch();
    open_test();
    repeat (5) begin
      check_next("backward branch");
    end
    close_test("backward branch");
  endtask

  task automatic hit_reuse();
    int base;
    open_test();
    base = req_log.size();
    repeat (9) begin
      check_next("hit reuse");
    end
    compare_count("hit reuse bus requests", 0, req_log.size() - base);
    close_test("hit reuse");
  endtask

  task automatic fence_refetch();
    int base;
    int queued;
    open_test();
    base = req_log.size();
    fence_i = 1'b1;
    queued = rx_q.size(); // issued before the fence.
    step();
    fence_i = 1'b0;
    repeat (queued + 3) begin
      check_next("fence.i");
    end
    compare_count("fence.i requests for line 0x80000038", 2,
                  line_requests(base, 32'h8000_0038));
    compare_count("fence.i requests in total", 4, req_log.size() - base);
    close_test("fence.i");
  endtask

  task automatic flush_refill();
    int queued;
    open_test();
    fence_i = 1'b1; // forces a refill to flush into.
    queued = rx_q.size();
    step();
    fence_i = 1'b0;
    while (!bus_req.arvalid) begin
      step();
    end
    flush.valid = 1'b1;
    flush.target = 32'h8000_0100;
    step();
    flush = '0;
    repeat (queued) begin
      check_next("flush");
    end
    exp_pc = 32'h8000_0100;
    repeat (6) begin
      check_next("flush");
    end
    close_test("flush");
  endtask

  task automatic credit_backpressure();
    int start;
    open_test();
    hold_credits = 1'b1;
    start = rx_total;
    repeat (hold_cycles) begin
      step();
    end
    if (rx_total - start > ysyx_core_pkg::fetch_credits) begin
      $display("credit back-pressure: %0d packets issued while decode held all credits",
               rx_total - start);
      errors++;
    end
    compare_count("credits held by decode", ysyx_core_pkg::fetch_credits, credit_q.size());
    hold_credits = 1'b0;
    while (rx_q.size() > 0) begin
      check_next("credit back-pressure");
    end
    repeat (8) begin
      check_next("credit back-pressure");
    end
    close_test("credit back-pressure");
  endtask

  initial begin
    wait (cycle >= timeout_cycles);
    $display("timeout after %0d cycles, fetch stopped making progress", cycle);
    $display("Errors found");
    $finish;
  end

  initial begin
    reset = 1'b1;
    bus_ready = 1'b1;
    bus_resp = '0;
    flush = '0;
    fence_i = 1'b0;
    credit_return = 1'b0;
    hold_credits = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rx_total = 0;
    resp_wait = 0;
    rng = 32'hc1e1ea37;
    exp_pc = 32'h8000_0000;
    repeat (2) begin
      @(posedge clock);
    end
    #1;
    reset = 1'b0;
    cold_start();
    backward_branch();
    hit_reuse();
    fence_refetch();
    flush_refill();
    credit_backpressure();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
